/* source/bpi_pkg.sv */
package bpi_pkg;

	////////////////////
	// Word types
	////////////////////
	typedef logic [15:0] word_t;       // Command or data word
	typedef logic [22:0] prom_addr_t;  // PROM word address

	// Opcode sits in bits 4..0 of a header word
	typedef enum logic [4:0] {
		OP_NOOP         = 5'h00,
		OP_READ_1       = 5'h02,
		OP_READ_N       = 5'h04,
		OP_READ_ARRAY   = 5'h05,
		OP_READ_STATUS  = 5'h06,
		OP_CLR_STATUS   = 5'h09,
		OP_BLOCK_ERASE  = 5'h0A,
		OP_PROGRAM      = 5'h0B,
		OP_LOAD_ADDRESS = 5'h17
	} opcode_t;

	// What the PROM returns on a plain read
	typedef enum logic [1:0] {
		RD_ARRAY  = 2'd0,
		RD_STATUS = 2'd1
	} read_mode_t;

	typedef enum logic [1:0] {
		BUS_WRITE = 2'b01,
		BUS_READ  = 2'b10
	} bus_op_t;

	////////////////////
	// PROM code words
	////////////////////
	localparam word_t CODE_READ_ARRAY    = 16'h00FF;
	localparam word_t CODE_READ_STATUS   = 16'h0070;
	localparam word_t CODE_CLR_STATUS    = 16'h0050;
	localparam word_t CODE_ERASE_SETUP   = 16'h0020;
	localparam word_t CODE_CONFIRM       = 16'h00D0;
	localparam word_t CODE_PROGRAM_SETUP = 16'h0040;

	////////////////////
	// Address masks
	////////////////////
	localparam prom_addr_t BANK_MASK         = 23'h780000;
	localparam prom_addr_t BLOCK_MASK        = 23'h7F0000;  // 64K-word main blocks
	localparam prom_addr_t PARAM_BLOCK_MASK  = 23'h7FC000;  // 16K-word parameter blocks
	localparam prom_addr_t PARAM_BLOCK_START = 23'h7F0000;

	// Ready flag in the PROM status byte
	localparam int SR_READY_BIT = 7;

endpackage

/* source/bpi_fifo.sv */
module bpi_fifo #(
	parameter int DEPTH = 2048,
	parameter type payload_t = bpi_pkg::word_t
) (
	input  logic CLK,
	input  logic local_rst,
	input  logic push,
	input  logic pop,
	input  payload_t wdata,
	output payload_t rdata,
	output logic empty,
	output logic full,
	output logic [$clog2(DEPTH+1)-1:0] count
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;  // Push into a full FIFO is lost
	assign do_pop = pop && !empty;
	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));
	assign rdata = mem[rd_ptr];  // First word falls through

	always_ff @(posedge CLK)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

/* source/bpi_cmd_decode.sv */
module bpi_cmd_decode (
	input  logic CLK,
	input  logic local_rst,
	input  logic enbl,
	input  logic dsbl,
	input  bpi_pkg::word_t cmd_word,
	input  logic cmd_empty,
	output logic cmd_pop,
	output logic start,
	output logic load_addr,
	output bpi_pkg::opcode_t opcode,
	output logic [10:0] count,
	output logic [6:0] base,
	output bpi_pkg::word_t offset,
	output bpi_pkg::word_t data,
	input  logic done
);
	import bpi_pkg::*;

	typedef enum logic [1:0] {D_HEADER, D_EXTRA, D_START, D_WAIT} dec_state_t;

	dec_state_t state;
	logic parse_en;

	// Pop only while words wait and parsing is on
	assign cmd_pop = parse_en && !cmd_empty && ((state == D_HEADER) || (state == D_EXTRA));
	assign start = (state == D_START);

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			parse_en <= 1'b0;
		else if (enbl)
			parse_en <= 1'b1;  // enbl beats dsbl
		else if (dsbl)
			parse_en <= 1'b0;
	end

	////////////////////
	// Command FSM
	////////////////////
	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state <= D_HEADER;
			load_addr <= 1'b0;
			opcode <= OP_NOOP;
			base <= '0;
			offset <= '0;
		end
		else
		begin
			load_addr <= 1'b0;
			case (state)
				D_HEADER:
					if (cmd_pop)
					begin
						opcode <= opcode_t'(cmd_word[4:0]);
						case (opcode_t'(cmd_word[4:0]))
							OP_LOAD_ADDRESS, OP_PROGRAM: state <= D_EXTRA;
							OP_READ_1, OP_READ_N, OP_READ_ARRAY, OP_READ_STATUS,
							OP_CLR_STATUS, OP_BLOCK_ERASE: state <= D_START;
							default: state <= D_HEADER;  // NoOp or unknown, dropped
						endcase
					end
				D_EXTRA:
					if (cmd_pop)
					begin
						if (opcode == OP_LOAD_ADDRESS)
						begin
							// Address kept here, sequencer told by a pulse
							base <= count[6:0];
							offset <= cmd_word;
							load_addr <= 1'b1;
							state <= D_HEADER;
						end
						else
							state <= D_START;  // Program data captured below
					end
				D_START: state <= D_WAIT;
				D_WAIT:
					if (done)
						state <= D_HEADER;
				default: state <= D_HEADER;
			endcase
		end
	end

	// Count field and program data
	always_ff @(posedge CLK)
	begin
		if (cmd_pop && (state == D_HEADER))
			count <= cmd_word[15:5];
		if (cmd_pop && (state == D_EXTRA) && (opcode == OP_PROGRAM))
			data <= cmd_word;
	end

endmodule

/* source/bpi_bus_sequencer.sv */
module bpi_bus_sequencer (
	input  logic CLK,
	input  logic local_rst,
	input  logic start,
	input  logic load_addr,
	input  bpi_pkg::opcode_t opcode,
	input  logic [10:0] count,
	input  logic [6:0] base,
	input  bpi_pkg::word_t offset,
	input  bpi_pkg::word_t data,
	output logic done,
	output logic execute,
	output bpi_pkg::bus_op_t bus_op,
	output bpi_pkg::prom_addr_t bus_addr,
	output bpi_pkg::word_t bus_data_to,
	input  logic busy,
	input  logic [7:0] sr,
	output bpi_pkg::read_mode_t read_mode,
	output logic user_read
);
	import bpi_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_EXEC, S_WAIT, S_DONE} seq_state_t;
	typedef enum logic [1:0] {STEP_FIRST, STEP_SECOND, STEP_POLL} step_t;

	seq_state_t state;
	step_t step;
	word_t run_offset;
	logic [10:0] remaining;  // Read_n words still to go after this one
	prom_addr_t waddr;
	prom_addr_t bank_addr;
	prom_addr_t block_addr;
	logic is_read;
	logic two_cycle;
	logic cycle_end;

	assign waddr = {base, run_offset};
	assign bank_addr = waddr & BANK_MASK;
	assign block_addr = (waddr >= PARAM_BLOCK_START) ? (waddr & PARAM_BLOCK_MASK)
		: (waddr & BLOCK_MASK);

	assign is_read = (opcode == OP_READ_1) || (opcode == OP_READ_N);
	assign two_cycle = (opcode == OP_BLOCK_ERASE) || (opcode == OP_PROGRAM);
	assign cycle_end = (state == S_WAIT) && !busy;  // PROM dropped busy

	assign execute = (state == S_EXEC);
	assign done = (state == S_DONE);
	assign user_read = is_read && ((state == S_EXEC) || (state == S_WAIT));

	////////////////////
	// Bus cycle contents
	////////////////////
	always_comb
	begin
		bus_op = BUS_WRITE;
		bus_addr = bank_addr;
		bus_data_to = '0;
		if (step == STEP_POLL)
			bus_op = BUS_READ;  // Status read at the bank
		else
			case (opcode)
				OP_READ_1, OP_READ_N:
				begin
					bus_op = BUS_READ;
					bus_addr = waddr;
				end
				OP_READ_ARRAY: bus_data_to = CODE_READ_ARRAY;
				OP_READ_STATUS: bus_data_to = CODE_READ_STATUS;
				OP_CLR_STATUS: bus_data_to = CODE_CLR_STATUS;
				OP_BLOCK_ERASE:
				begin
					bus_addr = block_addr;
					bus_data_to = (step == STEP_SECOND) ? CODE_CONFIRM : CODE_ERASE_SETUP;
				end
				OP_PROGRAM:
				begin
					bus_addr = waddr;
					bus_data_to = (step == STEP_SECOND) ? data : CODE_PROGRAM_SETUP;
				end
				default: bus_data_to = CODE_READ_ARRAY;
			endcase
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state <= S_IDLE;
			step <= STEP_FIRST;
			remaining <= '0;
			run_offset <= '0;
			read_mode <= RD_ARRAY;
		end
		else
		begin
			if (load_addr)
				run_offset <= offset;
			else if (cycle_end && is_read)
				run_offset <= run_offset + 1'b1;  // Next consecutive word

			case (state)
				S_IDLE:
					if (start)
					begin
						state <= S_EXEC;
						step <= STEP_FIRST;
						remaining <= (opcode == OP_READ_N) ? count : '0;
						case (opcode)
							OP_READ_ARRAY: read_mode <= RD_ARRAY;
							OP_READ_STATUS, OP_BLOCK_ERASE, OP_PROGRAM: read_mode <= RD_STATUS;
							default: read_mode <= read_mode;
						endcase
					end
				S_EXEC: state <= S_WAIT;
				S_WAIT:
					if (!busy)
					begin
						state <= S_DONE;
						if (is_read && (remaining != '0))
						begin
							remaining <= remaining - 1'b1;
							state <= S_EXEC;
						end
						else if (two_cycle && (step == STEP_FIRST))
						begin
							step <= STEP_SECOND;
							state <= S_EXEC;
						end
						else if (two_cycle && (step == STEP_SECOND))
						begin
							step <= STEP_POLL;
							state <= S_EXEC;
						end
						else if ((step == STEP_POLL) && !sr[SR_READY_BIT])
							state <= S_EXEC;  // Still busy inside the PROM
					end
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* source/bpi_readback.sv */
module bpi_readback #(
	parameter int RBK_DEPTH = 2048
) (
	input  logic CLK,
	input  logic local_rst,
	input  logic load_data,
	input  bpi_pkg::word_t data_from,
	input  bpi_pkg::read_mode_t read_mode,
	input  logic user_read,
	input  logic cmd_empty,
	input  logic cmd_full,
	input  logic rbk_re,
	output bpi_pkg::word_t rbk_data,
	output logic [$clog2(RBK_DEPTH+1)-1:0] rbk_cnt,
	output logic [7:0] sr,
	output bpi_pkg::word_t status
);
	import bpi_pkg::*;

	word_t rbk_head;
	logic rbk_push;
	logic rbk_empty;
	logic rbk_full;

	assign rbk_push = load_data && user_read;  // Only user reads go back to the host

	bpi_fifo #(
		.DEPTH(RBK_DEPTH),
		.payload_t(word_t)
	) u_rbk_fifo (
		.CLK(CLK),
		.local_rst(local_rst),
		.push(rbk_push),
		.pop(rbk_re),
		.wdata(data_from),
		.rdata(rbk_head),
		.empty(rbk_empty),
		.full(rbk_full),
		.count(rbk_cnt)
	);

	// Last PROM status byte
	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			sr <= '0;
		else if (load_data && (read_mode == RD_STATUS))
			sr <= data_from[7:0];
	end

	// Head word registered on the pop
	always_ff @(posedge CLK)
	begin
		if (rbk_re)
			rbk_data <= rbk_head;
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			status <= '0;
		else
			status <= {rbk_empty, rbk_full, 2'b00, cmd_empty, cmd_full, 2'b00, sr};
	end

endmodule

/* source/bpi_ctrl_top.sv */
module bpi_ctrl_top #(
	parameter int CMD_DEPTH = 2048,
	parameter int RBK_DEPTH = 2048
) (
	input  logic CLK,
	input  logic local_rst,
	input  logic cmd_we,
	input  bpi_pkg::word_t cmd_data,
	input  logic rbk_re,
	input  logic enbl,
	input  logic dsbl,
	output bpi_pkg::word_t rbk_data,
	output logic [$clog2(RBK_DEPTH+1)-1:0] rbk_cnt,
	output bpi_pkg::word_t status,
	input  logic busy,
	input  logic load_data,
	input  bpi_pkg::word_t data_from,
	output logic execute,
	output bpi_pkg::bus_op_t bus_op,
	output bpi_pkg::prom_addr_t bus_addr,
	output bpi_pkg::word_t bus_data_to
);
	import bpi_pkg::*;

	word_t cmd_word;
	logic cmd_empty;
	logic cmd_full;
	logic cmd_pop;
	logic start;
	logic load_addr;
	logic done;
	opcode_t opcode;
	logic [10:0] count;
	logic [6:0] base;
	word_t offset;
	word_t data;
	read_mode_t read_mode;
	logic user_read;
	logic [7:0] sr;

	////////////////////
	// Command path
	////////////////////
	bpi_fifo #(
		.DEPTH(CMD_DEPTH),
		.payload_t(word_t)
	) u_cmd_fifo (
		.CLK(CLK),
		.local_rst(local_rst),
		.push(cmd_we),
		.pop(cmd_pop),
		.wdata(cmd_data),
		.rdata(cmd_word),
		.empty(cmd_empty),
		.full(cmd_full),
		.count()
	);

	bpi_cmd_decode u_decode (
		.CLK(CLK),
		.local_rst(local_rst),
		.enbl(enbl),
		.dsbl(dsbl),
		.cmd_word(cmd_word),
		.cmd_empty(cmd_empty),
		.cmd_pop(cmd_pop),
		.start(start),
		.load_addr(load_addr),
		.opcode(opcode),
		.count(count),
		.base(base),
		.offset(offset),
		.data(data),
		.done(done)
	);

	// Execute stage drives the PROM bus
	bpi_bus_sequencer u_sequencer (
		.CLK(CLK),
		.local_rst(local_rst),
		.start(start),
		.load_addr(load_addr),
		.opcode(opcode),
		.count(count),
		.base(base),
		.offset(offset),
		.data(data),
		.done(done),
		.execute(execute),
		.bus_op(bus_op),
		.bus_addr(bus_addr),
		.bus_data_to(bus_data_to),
		.busy(busy),
		.sr(sr),
		.read_mode(read_mode),
		.user_read(user_read)
	);

	bpi_readback #(
		.RBK_DEPTH(RBK_DEPTH)
	) u_readback (
		.CLK(CLK),
		.local_rst(local_rst),
		.load_data(load_data),
		.data_from(data_from),
		.read_mode(read_mode),
		.user_read(user_read),
		.cmd_empty(cmd_empty),
		.cmd_full(cmd_full),
		.rbk_re(rbk_re),
		.rbk_data(rbk_data),
		.rbk_cnt(rbk_cnt),
		.sr(sr),
		.status(status)
	);

endmodule

/* test/bpi_prom_model.sv */
module bpi_prom_model (
	input  logic CLK,
	input  logic local_rst,
	input  logic execute,
	input  bpi_pkg::bus_op_t bus_op,
	input  bpi_pkg::prom_addr_t bus_addr,
	input  bpi_pkg::word_t bus_data_to,
	output logic busy,
	output logic load_data,
	output bpi_pkg::word_t data_from
);
	timeunit 1ns;
	timeprecision 100ps;
	import bpi_pkg::*;

	localparam logic [1:0] P_NONE = 2'd0;
	localparam logic [1:0] P_ERASE = 2'd1;
	localparam logic [1:0] P_PROG = 2'd2;

	word_t mem [256];
	logic [2:0] lat [256];   // Busy length per bus cycle
	logic status_mode;       // Reads return the status byte
	logic [1:0] pending;     // Second half of a two-cycle write
	logic [2:0] left;
	logic is_rd;
	prom_addr_t cyc_addr;
	prom_addr_t clr_addr;    // Where the last clear status code landed
	int clr_cnt;
	int n_cycles;

	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = {i[7:0], i[7:0] ^ 8'h5A};
	end

	task automatic set_latency(input int idx, input int len);
		lat[idx] = 3'(len);
	endtask

	always @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			busy <= 1'b0;
			load_data <= 1'b0;
			data_from <= '0;
			status_mode <= 1'b0;
			pending <= P_NONE;
			left <= '0;
			is_rd <= 1'b0;
			cyc_addr <= '0;
			clr_addr <= '0;
			clr_cnt <= 0;
			n_cycles <= 0;
		end
		else
		begin
			load_data <= 1'b0;
			if (execute)
			begin
				busy <= 1'b1;
				left <= lat[n_cycles[7:0]] - 3'd1;
				n_cycles <= n_cycles + 1;
				cyc_addr <= bus_addr;
				is_rd <= (bus_op == BUS_READ);
				if (bus_op == BUS_WRITE)
					case (pending)
						P_ERASE:
						begin
							if (bus_data_to == 16'h00D0)  // Confirm
								for (int i = 0; i < 256; i++)
									mem[i] <= 16'hFFFF;
							pending <= P_NONE;
						end
						P_PROG:
						begin
							mem[bus_addr[7:0]] <= bus_data_to;
							pending <= P_NONE;
						end
						default:
							case (bus_data_to)
								16'h00FF: status_mode <= 1'b0;
								16'h0070: status_mode <= 1'b1;
								16'h0050:
								begin
									clr_addr <= bus_addr;
									clr_cnt <= clr_cnt + 1;
								end
								16'h0020:
								begin
									pending <= P_ERASE;
									status_mode <= 1'b1;
								end
								16'h0040:
								begin
									pending <= P_PROG;
									status_mode <= 1'b1;
								end
								default: ;
							endcase
					endcase
			end
			else if (busy)
			begin
				// Read data comes in the last busy cycle
				if (left == 3'd1)
				begin
					load_data <= is_rd;
					data_from <= status_mode ? 16'h0080 : mem[cyc_addr[7:0]];
				end
				if (left == 3'd0)
					busy <= 1'b0;
				else
					left <= left - 3'd1;
			end
		end
	end

endmodule

/* test/bpi_ctrl_assert.sv */
module bpi_ctrl_assert (
	input  logic CLK,
	input  logic local_rst,
	input  logic execute,
	input  logic busy,
	input  logic done,
	input  bpi_pkg::prom_addr_t bus_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	int fails = 0;

	// A new cycle only on an idle bus
	exec_idle: assert property (@(posedge CLK) disable iff (local_rst) execute |-> !busy)
		else
		begin
			fails++;
			$error("execute raised while busy is high");
		end

	done_pulse: assert property (@(posedge CLK) disable iff (local_rst) done |=> !done)
		else
		begin
			fails++;
			$error("done held longer than one cycle");
		end

	addr_hold: assert property (@(posedge CLK) disable iff (local_rst)
		busy && $past(busy) |-> $stable(bus_addr))
		else
		begin
			fails++;
			$error("bus_addr changed inside a busy window");
		end

endmodule

bind bpi_bus_sequencer bpi_ctrl_assert u_bus_assert (
	.CLK(CLK),
	.local_rst(local_rst),
	.execute(execute),
	.busy(busy),
	.done(done),
	.bus_addr(bus_addr)
);

/* test/bpi_ctrl_tb.sv */
module bpi_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import bpi_pkg::*;

	localparam int DEPTH = 64;
	localparam int MAX_ENTRIES = 32;
	localparam int CYCLES_PER_ENTRY = 200;
	localparam int CHK_NONE = 0;
	localparam int CHK_CLR = 1;  // Clear status code seen by the PROM

	logic CLK = 1'b0;
	logic local_rst;
	logic cmd_we;
	word_t cmd_data;
	logic rbk_re;
	logic enbl;
	logic dsbl;
	word_t rbk_data;
	logic [$clog2(DEPTH+1)-1:0] rbk_cnt;
	word_t status;
	logic busy;
	logic load_data;
	word_t data_from;
	logic execute;
	bus_op_t bus_op;
	prom_addr_t bus_addr;
	word_t bus_data_to;

	////////////////////
	// Stimulus table
	////////////////////
	word_t e_hdr [MAX_ENTRIES];
	word_t e_ext [MAX_ENTRIES];
	bit e_has_ext [MAX_ENTRIES];
	bit e_drain [MAX_ENTRIES];
	int e_n [MAX_ENTRIES];    // Words expected back
	int e_chk [MAX_ENTRIES];
	bit e_gate [MAX_ENTRIES]; // Written while parsing is off
	int n_entries = 0;

	// Mirror of the PROM and of the controller address
	word_t mirror [256];
	logic [6:0] m_base = '0;
	word_t m_off = '0;
	bit m_status = 1'b0;
	logic [7:0] m_sr = '0;  // Last status byte the controller holds
	prom_addr_t m_clr;
	word_t exp_q [$];

	int mismatches = 0;
	int failures = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int done_cnt = 0;
	int exec_cnt = 0;

	always #2 CLK = ~CLK;

	bpi_ctrl_top #(
		.CMD_DEPTH(DEPTH),
		.RBK_DEPTH(DEPTH)
	) dut (
		.CLK(CLK),
		.local_rst(local_rst),
		.cmd_we(cmd_we),
		.cmd_data(cmd_data),
		.rbk_re(rbk_re),
		.enbl(enbl),
		.dsbl(dsbl),
		.rbk_data(rbk_data),
		.rbk_cnt(rbk_cnt),
		.status(status),
		.busy(busy),
		.load_data(load_data),
		.data_from(data_from),
		.execute(execute),
		.bus_op(bus_op),
		.bus_addr(bus_addr),
		.bus_data_to(bus_data_to)
	);

	bpi_prom_model prom (
		.CLK(CLK),
		.local_rst(local_rst),
		.execute(execute),
		.bus_op(bus_op),
		.bus_addr(bus_addr),
		.bus_data_to(bus_data_to),
		.busy(busy),
		.load_data(load_data),
		.data_from(data_from)
	);

	always @(posedge CLK)
	begin
		if (execute)
			exec_cnt <= exec_cnt + 1;
		if (dut.done)
			done_cnt <= done_cnt + 1;
	end

	always @(posedge CLK)
	begin
		cycles++;
		if ((cycle_limit != 0) && (cycles >= cycle_limit))
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic word_t header(input opcode_t op, input logic [10:0] cnt);
		return {cnt, op};
	endfunction

	function automatic bit reaches_sequencer(input opcode_t op);
		return (op != OP_NOOP) && (op != OP_LOAD_ADDRESS);
	endfunction

	task automatic note_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] expv);
		mismatches++;
		$display("MISMATCH %0t ns: %s got %h expected %h", $time, what, got, expv);
	endtask

	task automatic note_failure(input string msg);
		failures++;
		$display("ERROR %0t ns: %s", $time, msg);
	endtask

	task automatic add_entry(input word_t h, input word_t x, input bit has_x,
		input bit drain_it, input int n, input int chk, input bit gate);
		e_hdr[n_entries] = h;
		e_ext[n_entries] = x;
		e_has_ext[n_entries] = has_x;
		e_drain[n_entries] = drain_it;
		e_n[n_entries] = n;
		e_chk[n_entries] = chk;
		e_gate[n_entries] = gate;
		n_entries++;
	endtask

	task automatic build_table();
		word_t d0;
		word_t d1;
		word_t d2;
		d0 = word_t'($urandom);
		d1 = word_t'($urandom);
		d2 = word_t'($urandom);
		// Program then read back
		add_entry(header(OP_LOAD_ADDRESS, 11'd5), 16'h0010, 1, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_PROGRAM, 11'd0), d0, 1, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_ARRAY, 11'd0), 16'h0, 0, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_1, 11'd0), 16'h0, 0, 1, 1, CHK_NONE, 0);
		add_entry(header(OP_PROGRAM, 11'd0), d1, 1, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_ARRAY, 11'd0), 16'h0, 0, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_N, 11'd5), 16'h0, 0, 1, 6, CHK_NONE, 0);
		// Erase
		add_entry(header(OP_BLOCK_ERASE, 11'd0), 16'h0, 0, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_ARRAY, 11'd0), 16'h0, 0, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_LOAD_ADDRESS, 11'd5), 16'h0020, 1, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_N, 11'd3), 16'h0, 0, 1, 4, CHK_NONE, 0);
		// Status register
		add_entry(header(OP_READ_STATUS, 11'd0), 16'h0, 0, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_1, 11'd0), 16'h0, 0, 1, 1, CHK_NONE, 0);
		add_entry(header(OP_LOAD_ADDRESS, 11'h4B), 16'h1234, 1, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_CLR_STATUS, 11'd0), 16'h0, 0, 0, 0, CHK_CLR, 0);
		add_entry(header(OP_READ_ARRAY, 11'd0), 16'h0, 0, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_NOOP, 11'd7), 16'h0, 0, 0, 0, CHK_NONE, 0);
		// Parsing gated off while writing
		add_entry(header(OP_LOAD_ADDRESS, 11'h4B), 16'h0040, 1, 0, 0, CHK_NONE, 1);
		add_entry(header(OP_PROGRAM, 11'd0), d2, 1, 0, 0, CHK_NONE, 1);
		add_entry(header(OP_READ_ARRAY, 11'd0), 16'h0, 0, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_1, 11'd0), 16'h0, 0, 1, 1, CHK_NONE, 1);
		add_entry(header(OP_LOAD_ADDRESS, 11'd0), 16'h00FE, 1, 0, 0, CHK_NONE, 0);
		add_entry(header(OP_READ_N, 11'd2), 16'h0, 0, 1, 3, CHK_NONE, 0);
	endtask

	// Expected effect of one command on the mirror
	task automatic predict(input int i);
		opcode_t op;
		logic [10:0] cnt;
		int nwords;
		op = opcode_t'(e_hdr[i][4:0]);
		cnt = e_hdr[i][15:5];
		nwords = (op == OP_READ_N) ? int'(cnt) + 1 : 1;
		case (op)
			OP_LOAD_ADDRESS:
			begin
				m_base = cnt[6:0];
				m_off = e_ext[i];
			end
			OP_PROGRAM:
			begin
				mirror[m_off[7:0]] = e_ext[i];
				m_status = 1'b1;
				m_sr = 8'h80;  // Ready poll reply
			end
			OP_BLOCK_ERASE:
			begin
				for (int a = 0; a < 256; a++)
					mirror[a] = 16'hFFFF;
				m_status = 1'b1;
				m_sr = 8'h80;
			end
			OP_READ_ARRAY: m_status = 1'b0;
			OP_READ_STATUS: m_status = 1'b1;
			OP_CLR_STATUS: m_clr = {m_base, m_off} & 23'h780000;  // Bank of the address
			OP_READ_1, OP_READ_N:
				for (int w = 0; w < nwords; w++)
				begin
					exp_q.push_back(m_status ? 16'h0080 : mirror[m_off[7:0]]);
					if (m_status)
						m_sr = 8'h80;
					m_off = m_off + 16'd1;
				end
			default: ;
		endcase
	endtask

	task automatic write_word(input word_t w);
		cmd_we = 1'b1;
		cmd_data = w;
		@(negedge CLK);
		cmd_we = 1'b0;
	endtask

	task automatic pulse_enable();
		enbl = 1'b1;
		@(negedge CLK);
		enbl = 1'b0;
	endtask

	task automatic pulse_disable();
		dsbl = 1'b1;
		@(negedge CLK);
		dsbl = 1'b0;
	endtask

	task automatic pop_word(output word_t w);
		rbk_re = 1'b1;
		@(negedge CLK);
		rbk_re = 1'b0;
		w = rbk_data;  // Registered on the pop edge
	endtask

	task automatic run_entry(input int i);
		int done_before;
		int exec_before;
		int clr_before;
		word_t got;
		word_t expv;
		word_t exp_st;
		opcode_t op;
		op = opcode_t'(e_hdr[i][4:0]);
		done_before = done_cnt;
		clr_before = prom.clr_cnt;
		if (e_gate[i])
			pulse_disable();
		exec_before = exec_cnt;
		write_word(e_hdr[i]);
		if (e_has_ext[i])
			write_word(e_ext[i]);
		predict(i);
		if (e_gate[i])
		begin
			repeat (20) @(negedge CLK);
			assert (exec_cnt == exec_before)
				else note_failure("execute issued while parsing was disabled");
			assert (status[11] == 1'b0)
				else note_failure("status shows an empty command FIFO while words wait");
			pulse_enable();
		end
		while (!status[11])
			@(negedge CLK);
		if (reaches_sequencer(op))
			while (done_cnt == done_before)
				@(negedge CLK);
		repeat (2) @(negedge CLK);  // Status word settles

		if (e_chk[i] == CHK_CLR)
		begin
			assert (prom.clr_cnt == clr_before + 1)
				else note_failure("clear status code never reached the PROM bus");
			assert (prom.clr_addr == m_clr)
				else note_mismatch("clear status address", prom.clr_addr, m_clr);
		end

		// FIFO flags and status byte
		exp_st = {exp_q.size() == 0, exp_q.size() == DEPTH, 2'b00, 1'b1, 1'b0, 2'b00, m_sr};
		assert (status === exp_st)
			else note_mismatch("status word", status, exp_st);

		if (e_drain[i])
		begin
			assert (rbk_cnt == e_n[i])
				else note_mismatch("rbk_cnt before drain", rbk_cnt, e_n[i]);
			for (int w = 0; w < e_n[i]; w++)
			begin
				pop_word(got);
				expv = 16'hxxxx;
				if (exp_q.size() > 0)
					expv = exp_q.pop_front();
				assert (got === expv)
					else note_mismatch($sformatf("entry %0d word %0d", i, w), got, expv);
			end
			assert (rbk_cnt == 0)
				else note_failure("read-back FIFO still holds words after the drain");
			exp_q.delete();
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial
	begin
		void'($urandom(91495));
		local_rst = 1'b1;
		cmd_we = 1'b0;
		cmd_data = '0;
		rbk_re = 1'b0;
		enbl = 1'b0;
		dsbl = 1'b0;
		for (int a = 0; a < 256; a++)
		begin
			prom.set_latency(a, 2 + ($urandom % 4));
			mirror[a] = {a[7:0], a[7:0] ^ 8'h5A};  // Same fill as the PROM
		end
		build_table();
		cycle_limit = n_entries * CYCLES_PER_ENTRY;

		repeat (8) @(posedge CLK);
		@(negedge CLK);
		assert ((status == 16'h0000) && (execute == 1'b0) && (rbk_cnt == 0))
			else note_failure("outputs not cleared during reset");
		local_rst = 1'b0;
		@(negedge CLK);
		pulse_enable();

		for (int i = 0; i < n_entries; i++)
			run_entry(i);
		repeat (4) @(negedge CLK);

		$display("Run complete: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatches, failures, dut.u_sequencer.u_bus_assert.fails);
		if ((mismatches == 0) && (failures == 0) && (dut.u_sequencer.u_bus_assert.fails == 0))
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* vlog.f */
source/bpi_pkg.sv
source/bpi_fifo.sv
source/bpi_cmd_decode.sv
source/bpi_bus_sequencer.sv
source/bpi_readback.sv
source/bpi_ctrl_top.sv
test/bpi_prom_model.sv
test/bpi_ctrl_assert.sv
test/bpi_ctrl_tb.sv

/* Bender.yml */
package:
  name: bpi_ctrl

sources:
  - files:
      - source/bpi_pkg.sv
      - source/bpi_fifo.sv
      - source/bpi_cmd_decode.sv
      - source/bpi_bus_sequencer.sv
      - source/bpi_readback.sv
      - source/bpi_ctrl_top.sv
  - target: test
    files:
      - test/bpi_prom_model.sv
      - test/bpi_ctrl_assert.sv
      - test/bpi_ctrl_tb.sv
